//--- dv/ex_unit_tb.sv
`timescale 1ns/1ps
`default_nettype none

module ex_unit_tb import ex_pkg::*; ();

	localparam int DATA_W  = 32;
	localparam int TIMEOUT = 1000; // cycles allowed for the queue to drain

	typedef logic [DATA_W-1:0] data_t;

	// ex/mem register image after an edge, plus the same-cycle outputs before it
	typedef struct packed {
		logic                  valid;
		data_t                 out;
		logic [REG_ADDR_W-1:0] dst;
		logic                  we_n;
		mem_op_e               mem_op;
		data_t                 wr_data;
		logic                  branch;
		data_t                 target;
	} exp_t;

	logic                  clk;
	logic                  rst_n;
	logic                  id_valid;
	data_t                 alu_in0;
	data_t                 alu_in1;
	alu_op_e               alu_op;
	data_t                 cmp_in0;
	data_t                 cmp_in1;
	cmp_op_e               cmp_op;
	ex_sel_e               ex_sel;
	data_t                 pc_next;
	logic                  jump_en;
	logic                  branch_en;
	logic [REG_ADDR_W-1:0] id_dst_addr;
	logic                  id_gpr_we_n;
	mem_op_e               id_mem_op;
	data_t                 id_mem_wr_data;
	data_t                 pc_target;
	logic                  branch;
	logic                  ex_valid;
	data_t                 ex_out;
	logic [REG_ADDR_W-1:0] ex_dst_addr;
	logic                  ex_gpr_we_n;
	mem_op_e               ex_mem_op;
	data_t                 ex_mem_wr_data;

	integer seed = 32'h3232b201;
	int     err_cnt = 0;
	int     chk_cnt = 0;
	int     tmo_cnt = 0;
	exp_t   exp_q[$]; // one entry per driven cycle
	exp_t   held;     // model of the ex/mem register

	ex_unit #(.DATA_W(DATA_W)) u_ex_unit (.*);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk; // 8 ns period
	end

	function automatic data_t rnd();
		return data_t'($random(seed));
	endfunction

	// expected outputs of one instruction, built from the opcode rules
	function automatic exp_t ref_ex(input logic v, input alu_op_e aop, input data_t a0,
		input data_t a1, input cmp_op_e cop, input data_t c0, input data_t c1,
		input ex_sel_e sel, input data_t pcn, input logic jmp, input logic br,
		input logic [REG_ADDR_W-1:0] dst, input logic we_n, input mem_op_e mop,
		input data_t wd, input exp_t prev);
		exp_t                      e;
		data_t                     alu_v;
		logic                      cond;
		logic                      lt_s;
		logic [$clog2(DATA_W)-1:0] sh;
		sh = a1[$clog2(DATA_W)-1:0]; // only low bits count
		case (aop)
			ALU_ADD: alu_v = a0 + a1;
			ALU_SUB: alu_v = a0 + ~a1 + data_t'(1); // two's complement
			ALU_AND: alu_v = a0 & a1;
			ALU_OR:  alu_v = a0 | a1;
			ALU_XOR: alu_v = a0 ^ a1;
			ALU_SLL: alu_v = a0 << sh;
			ALU_SRL: alu_v = a0 >> sh;
			default: alu_v = data_t'({{DATA_W{a0[DATA_W-1]}}, a0} >> sh); // sra, sign copies
		endcase
		lt_s = (c0[DATA_W-1] != c1[DATA_W-1]) ? c0[DATA_W-1] : (c0 < c1); // signs differ
		case (cop)
			CMP_EQ:  cond = (c0 == c1);
			CMP_NE:  cond = (c0 != c1);
			CMP_LT:  cond = lt_s;
			CMP_LTU: cond = (c0 < c1);
			CMP_GE:  cond = !lt_s;
			default: cond = !(c0 < c1); // geu
		endcase
		e        = prev; // data fields hold through a bubble
		e.valid  = v;
		e.branch = v && (jmp || (br && cond));
		e.target = alu_v;
		if (v) begin
			case (sel)
				EX_OUT_CMP: e.out = {{(DATA_W-1){1'b0}}, cond};
				EX_OUT_PCN: e.out = pcn;
				default:    e.out = alu_v;
			endcase
			e.dst     = dst;
			e.we_n    = we_n;
			e.mem_op  = mop;
			e.wr_data = wd;
		end else begin
			e.we_n   = 1'b1;
			e.mem_op = MEM_NOP;
		end
		return e;
	endfunction

	task automatic check_data(input string name, input data_t got, input data_t exp);
		chk_cnt++;
		if (got !== exp) begin
			err_cnt++;
			$display("Error: %s got %h expected %h at %0t", name, got, exp, $time);
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		chk_cnt++;
		if (got !== exp) begin
			err_cnt++;
			$display("Error: %s got %h expected %h at %0t", name, got, exp, $time);
		end
	endtask

	task automatic check_mem_op(input string name, input mem_op_e got, input mem_op_e exp);
		chk_cnt++;
		if (got !== exp) begin
			err_cnt++;
			$display("Error: %s got %h expected %h at %0t", name, got, exp, $time);
		end
	endtask

	task automatic check_addr(input string name, input logic [REG_ADDR_W-1:0] got,
		input logic [REG_ADDR_W-1:0] exp);
		chk_cnt++;
		if (got !== exp) begin
			err_cnt++;
			$display("Error: %s got %h expected %h at %0t", name, got, exp, $time);
		end
	endtask

	// one cycle of stimulus, bypass fields and pc_next random
	task automatic drive(input logic v, input alu_op_e aop, input data_t a0, input data_t a1,
		input cmp_op_e cop, input data_t c0, input data_t c1, input ex_sel_e sel,
		input logic jmp, input logic br);
		@(negedge clk);
		id_valid       = v;
		alu_op         = aop;
		alu_in0        = a0;
		alu_in1        = a1;
		cmp_op         = cop;
		cmp_in0        = c0;
		cmp_in1        = c1;
		ex_sel         = sel;
		jump_en        = jmp;
		branch_en      = br;
		pc_next        = rnd();
		id_dst_addr    = REG_ADDR_W'($random(seed));
		id_gpr_we_n    = 1'($random(seed));
		id_mem_op      = mem_op_e'(2'($unsigned($random(seed)) % 3));
		id_mem_wr_data = rnd();
		held = ref_ex(v, aop, a0, a1, cop, c0, c1, sel, pc_next, jmp, br, id_dst_addr,
			id_gpr_we_n, id_mem_op, id_mem_wr_data, held);
		exp_q.push_back(held);
	endtask

	task automatic drive_random(input logic v);
		logic jmp;
		jmp = 1'($random(seed));
		drive(v, alu_op_e'(3'($random(seed))), rnd(), rnd(),
			cmp_op_e'(3'($unsigned($random(seed)) % 6)), rnd(), rnd(),
			ex_sel_e'(2'($unsigned($random(seed)) % 3)), jmp, !jmp && 1'($random(seed)));
	endtask

	task automatic wait_drain();
		int n;
		n = 0;
		while (exp_q.size() != 0 && n < TIMEOUT) begin
			@(negedge clk); // checks of the popped entry are done by now
			n++;
		end
		if (exp_q.size() != 0) begin
			tmo_cnt++;
			$display("Timeout: expected results still pending after %0d cycles", TIMEOUT);
		end
	endtask

	// comb outputs before the edge, register after it
	initial begin : compare_proc
		exp_t e;
		forever begin
			@(posedge clk);
			if (exp_q.size() != 0) begin
				e = exp_q.pop_front();
				check_bit("branch", branch, e.branch);
				check_data("pc_target", pc_target, e.target);
				#1;
				check_bit("ex_valid", ex_valid, e.valid);
				check_data("ex_out", ex_out, e.out);
				check_addr("ex_dst_addr", ex_dst_addr, e.dst);
				check_bit("ex_gpr_we_n", ex_gpr_we_n, e.we_n);
				check_mem_op("ex_mem_op", ex_mem_op, e.mem_op);
				check_data("ex_mem_wr_data", ex_mem_wr_data, e.wr_data);
			end
		end
	end

	initial begin
		data_t x;
		rst_n          = 1'b0;
		id_valid       = 1'b0;
		alu_in0        = '0;
		alu_in1        = '0;
		alu_op         = ALU_ADD;
		cmp_in0        = '0;
		cmp_in1        = '0;
		cmp_op         = CMP_EQ;
		ex_sel         = EX_OUT_ALU;
		pc_next        = '0;
		jump_en        = 1'b0;
		branch_en      = 1'b0;
		id_dst_addr    = '0;
		id_gpr_we_n    = 1'b1;
		id_mem_op      = MEM_NOP;
		id_mem_wr_data = '0;
		held           = '0;
		held.we_n      = 1'b1;
		held.mem_op    = MEM_NOP;
		repeat (5) begin
			@(negedge clk);
			check_bit("ex_valid", ex_valid, 1'b0);
			check_bit("ex_gpr_we_n", ex_gpr_we_n, 1'b1);
			check_mem_op("ex_mem_op", ex_mem_op, MEM_NOP);
		end
		rst_n = 1'b1;
		held = ref_ex(id_valid, alu_op, alu_in0, alu_in1, cmp_op, cmp_in0, cmp_in1, ex_sel,
			pc_next, jump_en, branch_en, id_dst_addr, id_gpr_we_n, id_mem_op,
			id_mem_wr_data, held);
		exp_q.push_back(held); // first edge after release sees the idle inputs
		drive_random(1'b0); // then a random bubble
		for (int i = 0; i < 8; i++) begin
			drive(1'b1, alu_op_e'(3'(i)), rnd(), rnd(), CMP_EQ, rnd(), rnd(), EX_OUT_ALU, 0, 0);
		end
		drive(1'b1, ALU_SLL, 32'h0000_0001, 32'd31, CMP_EQ, rnd(), rnd(), EX_OUT_ALU, 0, 0);
		drive(1'b1, ALU_SRA, 32'h8000_0000, 32'd31, CMP_EQ, rnd(), rnd(), EX_OUT_ALU, 0, 0);
		drive(1'b1, ALU_SRL, 32'h8000_0000, 32'hffff_ffff, CMP_EQ, 0, 0, EX_OUT_ALU, 0, 0);
		drive(1'b1, ALU_SRA, 32'h8765_4321, 32'hffff_ffe4, CMP_EQ, 0, 0, EX_OUT_ALU, 0, 0);
		drive(1'b1, ALU_SUB, 32'd0, 32'd1, CMP_EQ, rnd(), rnd(), EX_OUT_ALU, 0, 0); // wraps
		for (int i = 0; i < 6; i++) begin
			x = rnd();
			drive(1'b1, ALU_ADD, rnd(), rnd(), cmp_op_e'(3'(i)), x, x, EX_OUT_CMP, 0, 0);
			drive(1'b1, ALU_ADD, 0, 0, cmp_op_e'(3'(i)), 32'h8000_0000, 32'd1, EX_OUT_CMP, 0, 0);
			drive(1'b1, ALU_ADD, 0, 0, cmp_op_e'(3'(i)), 32'd1, 32'h8000_0000, EX_OUT_CMP, 0, 0);
			drive(1'b1, ALU_ADD, rnd(), rnd(), cmp_op_e'(3'(i)), rnd(), rnd(), EX_OUT_CMP, 0, 0);
		end
		drive(1'b1, ALU_ADD, rnd(), rnd(), CMP_EQ, rnd(), rnd(), EX_OUT_PCN, 0, 0);
		x = rnd();
		drive(1'b1, ALU_ADD, rnd(), rnd(), CMP_NE, x, x, EX_OUT_PCN, 1, 0); // jump, cond false
		drive(1'b1, ALU_ADD, rnd(), rnd(), CMP_EQ, x, x, EX_OUT_ALU, 0, 1); // taken
		drive(1'b1, ALU_ADD, rnd(), rnd(), CMP_EQ, x, ~x, EX_OUT_ALU, 0, 1); // not taken
		drive(1'b0, ALU_ADD, rnd(), rnd(), CMP_EQ, x, x, EX_OUT_ALU, 1, 0); // jump on a gap
		drive(1'b0, ALU_ADD, rnd(), rnd(), CMP_EQ, x, x, EX_OUT_ALU, 0, 1);
		repeat (300) begin
			drive_random(($random(seed) & 3) != 0); // about one gap in four
		end
		wait_drain();
		$display("checks %0d, errors %0d, timeouts %0d", chk_cnt, err_cnt, tmo_cnt);
		if (err_cnt == 0 && tmo_cnt == 0) begin
			$display("TESTS PASSED");
		end else begin
			$display("TESTS FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- ex_unit.f
hw/ex_pkg.sv
hw/ex_bypass_if.sv
hw/alu.sv
hw/cmp.sv
hw/ex_stage.sv
hw/ex_unit.sv
dv/ex_unit_tb.sv

//--- hw/alu.sv
`timescale 1ns/1ps
`default_nettype none

module alu import ex_pkg::*; #(
	parameter int DATA_W = DATA_W_DEF
) (
	input  logic [DATA_W-1:0] arg0,
	input  logic [DATA_W-1:0] arg1,
	input  alu_op_e           op,
	output logic [DATA_W-1:0] val  // data result or jump/branch target
);

	localparam int SH_W = $clog2(DATA_W); // shift amount width

	logic [SH_W-1:0] shamt;

	assign shamt = arg1[SH_W-1:0]; // upper bits of arg1 ignored for shifts

	always_comb begin
		val = arg0 + arg1; // default, add
		case (op)
			ALU_ADD: begin
				val = arg0 + arg1;
			end
			ALU_SUB: begin
				val = arg0 - arg1; // modulo 2^DATA_W
			end
			ALU_AND: begin
				val = arg0 & arg1;
			end
			ALU_OR: begin
				val = arg0 | arg1;
			end
			ALU_XOR: begin
				val = arg0 ^ arg1;
			end
			ALU_SLL: begin
				val = arg0 << shamt;
			end
			ALU_SRL: begin
				val = arg0 >> shamt; // zero fill
			end
			ALU_SRA: begin
				val = $unsigned($signed(arg0) >>> shamt); // sign fill
			end
			default: begin
				val = arg0 + arg1;
			end
		endcase
	end

endmodule

`default_nettype wire

//--- hw/cmp.sv
`timescale 1ns/1ps
`default_nettype none

module cmp import ex_pkg::*; #(
	parameter int DATA_W = DATA_W_DEF
) (
	input  logic [DATA_W-1:0] arg0,
	input  logic [DATA_W-1:0] arg1,
	input  cmp_op_e           op,
	output logic              cond // 1 - condition holds
);

	logic eq;  // arg0 == arg1
	logic lt;  // signed less than
	logic ltu; // unsigned less than

	assign eq  = (arg0 == arg1);
	assign lt  = ($signed(arg0) < $signed(arg1));
	assign ltu = (arg0 < arg1);

	always_comb begin
		case (op)
			CMP_EQ:  cond = eq;
			CMP_NE:  cond = ~eq;
			CMP_LT:  cond = lt;
			CMP_LTU: cond = ltu;
			CMP_GE:  cond = ~lt;  // ge is not lt
			CMP_GEU: cond = ~ltu;
			default: cond = 1'b0; // codes 6, 7 unused
		endcase
	end

	// decode must never hand over one of the two spare opcodes
	always_comb begin
		assert ($isunknown(op) || op inside {CMP_EQ, CMP_NE, CMP_LT, CMP_LTU,
			CMP_GE, CMP_GEU})
		else $error("cmp: undefined opcode %0d", op);
	end

endmodule

`default_nettype wire

//--- hw/ex_bypass_if.sv
`timescale 1ns/1ps
`default_nettype none

// fields that ride from decode straight into the ex/mem register
interface ex_bypass_if import ex_pkg::*; #(
	parameter int DATA_W = DATA_W_DEF
) ();

	logic [REG_ADDR_W-1:0] dst_addr;    // destination gpr
	logic                  gpr_we_n;    // gpr write enable, active low
	mem_op_e               mem_op;      // load / store / none
	logic [DATA_W-1:0]     mem_wr_data; // store data

	modport src (
		output dst_addr,
		output gpr_we_n,
		output mem_op,
		output mem_wr_data
	);

	modport dst (
		input dst_addr,
		input gpr_we_n,
		input mem_op,
		input mem_wr_data
	);

endinterface

`default_nettype wire

//--- hw/ex_pkg.sv
`default_nettype none

package ex_pkg;

	// datapath width used when the top level does not override it
	localparam int DATA_W_DEF = 32;

	// register file address width, 32 gprs
	localparam int REG_ADDR_W = 5;

	// alu opcodes
	typedef enum logic [2:0] {
		ALU_ADD = 3'd0, // arg0 + arg1, also branch target
		ALU_SUB = 3'd1, // arg0 - arg1, wraps
		ALU_AND = 3'd2,
		ALU_OR  = 3'd3,
		ALU_XOR = 3'd4,
		ALU_SLL = 3'd5, // shift by low bits of arg1
		ALU_SRL = 3'd6,
		ALU_SRA = 3'd7  // sign kept
	} alu_op_e;

	// comparator opcodes, 6 of 8 codes used
	typedef enum logic [2:0] {
		CMP_EQ  = 3'd0,
		CMP_NE  = 3'd1,
		CMP_LT  = 3'd2, // signed
		CMP_LTU = 3'd3,
		CMP_GE  = 3'd4, // signed
		CMP_GEU = 3'd5
	} cmp_op_e;

	// stage result select
	typedef enum logic [1:0] {
		EX_OUT_ALU = 2'd0, // alu value
		EX_OUT_CMP = 2'd1, // condition bit, zero extended
		EX_OUT_PCN = 2'd2  // next pc, for link
	} ex_sel_e;

	// memory stage operation
	typedef enum logic [1:0] {
		MEM_NOP   = 2'd0,
		MEM_LOAD  = 2'd1,
		MEM_STORE = 2'd2
	} mem_op_e;

endpackage

`default_nettype wire

//--- hw/ex_stage.sv
`timescale 1ns/1ps
`default_nettype none

module ex_stage import ex_pkg::*; #(
	parameter int DATA_W = DATA_W_DEF
) (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  id_valid,       // one instruction this cycle
	ex_bypass_if.dst              byp,            // dst/we/mem bundle from decode
	input  logic [DATA_W-1:0]     alu_val,
	input  logic                  cmp_cond,
	input  ex_sel_e               ex_sel,
	input  logic [DATA_W-1:0]     pc_next,        // pc of following instruction
	input  logic                  jump_en,        // unconditional jump
	input  logic                  branch_en,      // conditional branch
	output logic [DATA_W-1:0]     pc_target,
	output logic                  branch,         // take branch or jump
	output logic                  ex_valid,
	output logic [DATA_W-1:0]     ex_out,
	output logic [REG_ADDR_W-1:0] ex_dst_addr,
	output logic                  ex_gpr_we_n,
	output mem_op_e               ex_mem_op,
	output logic [DATA_W-1:0]     ex_mem_wr_data
);

	logic [DATA_W-1:0] ex_out_d; // selected stage result, into the register

	always_comb begin
		case (ex_sel)
			EX_OUT_ALU: ex_out_d = alu_val;
			EX_OUT_CMP: ex_out_d = {{(DATA_W-1){1'b0}}, cmp_cond};
			EX_OUT_PCN: ex_out_d = pc_next; // link value
			default:    ex_out_d = alu_val;
		endcase
	end

	assign pc_target = alu_val; // alu adds base + offset for targets
	assign branch    = id_valid & (jump_en | (branch_en & cmp_cond));

	// ex/mem pipeline register
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			ex_valid       <= 1'b0;
			ex_out         <= '0;
			ex_dst_addr    <= '0;
			ex_gpr_we_n    <= 1'b1;
			ex_mem_op      <= MEM_NOP;
			ex_mem_wr_data <= '0;
		end else if (id_valid) begin
			ex_valid       <= 1'b1;
			ex_out         <= ex_out_d;
			ex_dst_addr    <= byp.dst_addr;
			ex_gpr_we_n    <= byp.gpr_we_n;
			ex_mem_op      <= byp.mem_op;
			ex_mem_wr_data <= byp.mem_wr_data;
		end else begin
			ex_valid    <= 1'b0;    // bubble
			ex_gpr_we_n <= 1'b1;    // no gpr write
			ex_mem_op   <= MEM_NOP; // no memory access
		end
	end

	// select must be meaningful for every real instruction
	a_sel_defined: assert property (@(posedge clk) disable iff (!rst_n)
		id_valid |-> ex_sel inside {EX_OUT_ALU, EX_OUT_CMP, EX_OUT_PCN})
		else $error("ex_stage: undefined ex_sel");

	// decode marks an instruction as jump or branch, not both
	a_jump_xor_branch: assert property (@(posedge clk) disable iff (!rst_n)
		!(jump_en && branch_en))
		else $error("ex_stage: jump_en and branch_en both set");

	// a bubble in the register never carries a gpr write
	a_bubble_no_write: assert property (@(posedge clk) disable iff (!rst_n)
		($past(rst_n) && !ex_valid) |-> ex_gpr_we_n)
		else $error("ex_stage: gpr write on a bubble");

endmodule

`default_nettype wire

//--- hw/ex_unit.sv
`timescale 1ns/1ps
`default_nettype none

module ex_unit import ex_pkg::*; #(
	parameter int DATA_W = DATA_W_DEF
) (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  id_valid,
	input  logic [DATA_W-1:0]     alu_in0,
	input  logic [DATA_W-1:0]     alu_in1,
	input  alu_op_e               alu_op,
	input  logic [DATA_W-1:0]     cmp_in0,
	input  logic [DATA_W-1:0]     cmp_in1,
	input  cmp_op_e               cmp_op,
	input  ex_sel_e               ex_sel,
	input  logic [DATA_W-1:0]     pc_next,
	input  logic                  jump_en,
	input  logic                  branch_en,
	input  logic [REG_ADDR_W-1:0] id_dst_addr,    // bypass in
	input  logic                  id_gpr_we_n,
	input  mem_op_e               id_mem_op,
	input  logic [DATA_W-1:0]     id_mem_wr_data,
	output logic [DATA_W-1:0]     pc_target,      // to fetch, same cycle
	output logic                  branch,
	output logic                  ex_valid,       // to mem stage, registered
	output logic [DATA_W-1:0]     ex_out,
	output logic [REG_ADDR_W-1:0] ex_dst_addr,
	output logic                  ex_gpr_we_n,
	output mem_op_e               ex_mem_op,
	output logic [DATA_W-1:0]     ex_mem_wr_data
);

	logic [DATA_W-1:0] alu_val;  // alu result
	logic              cmp_cond; // comparator result

	ex_bypass_if #(.DATA_W(DATA_W)) byp ();

	// plain bypass ports onto the bundle
	assign byp.dst_addr    = id_dst_addr;
	assign byp.gpr_we_n    = id_gpr_we_n;
	assign byp.mem_op      = id_mem_op;
	assign byp.mem_wr_data = id_mem_wr_data;

	alu #(.DATA_W(DATA_W)) u_alu (
		.arg0 (alu_in0),
		.arg1 (alu_in1),
		.op   (alu_op),
		.val  (alu_val)
	);

	cmp #(.DATA_W(DATA_W)) u_cmp (
		.arg0 (cmp_in0),
		.arg1 (cmp_in1),
		.op   (cmp_op),
		.cond (cmp_cond)
	);

	ex_stage #(.DATA_W(DATA_W)) u_ex_stage (
		.clk            (clk),
		.rst_n          (rst_n),
		.id_valid       (id_valid),
		.byp            (byp),
		.alu_val        (alu_val),
		.cmp_cond       (cmp_cond),
		.ex_sel         (ex_sel),
		.pc_next        (pc_next),
		.jump_en        (jump_en),
		.branch_en      (branch_en),
		.pc_target      (pc_target),
		.branch         (branch),
		.ex_valid       (ex_valid),
		.ex_out         (ex_out),
		.ex_dst_addr    (ex_dst_addr),
		.ex_gpr_we_n    (ex_gpr_we_n),
		.ex_mem_op      (ex_mem_op),
		.ex_mem_wr_data (ex_mem_wr_data)
	);

endmodule

`default_nettype wire

//--- run.sh
#!/bin/sh
# compile and run the ex_unit testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module ex_unit_tb -Mdir obj_dir -f ex_unit.f
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

out=$(./obj_dir/Vex_unit_tb)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if echo "$out" | grep -q "^TESTS PASSED$"; then
	exit 0
fi
exit 1
